// ==== hw/frame_config.svh ====
`ifndef FRAME_CONFIG_SVH
`define FRAME_CONFIG_SVH

// Pixel word, one 32-bit RGBA sample
`define FRAME_DATA_W 32

// Word address into the frame memory
`define FRAME_ADDR_W 32

// Stages between stream take and bus beat
`define FRAME_DELAY_DEPTH 3

// Triple buffering
`define FRAME_SLOTS 3

// On-chip store, enough for three small test frames
`define FRAME_MEM_WORDS 1024

`endif

// ==== hw/frame_pkg.sv ====
`include "frame_config.svh"

package frame_pkg;

	// One pixel word on the stream and on the bus
	typedef logic [`FRAME_DATA_W-1:0] pixel_t;

	// Word address
	typedef logic [`FRAME_ADDR_W-1:0] addr_t;

	// Burst encoding as on AXI
	typedef enum logic [1:0] {
		FIXED = 2'd0, // Pointer holds
		INCR  = 2'd1  // Pointer steps one word per beat
	} burst_kind_t;

	// Writer sequencing
	typedef enum logic [1:0] {
		IDLE,       // Waiting for start of frame
		RECEIVE,    // Taking pixels, counting lines
		FRAME_DONE  // Single cycle, frame handed off
	} writer_state_t;

endpackage

// ==== hw/mem_write_if.sv ====
`timescale 1ns/10ps
`include "frame_config.svh"

interface mem_write_if import frame_pkg::*; ();

	logic                       start; // Burst header strobe
	addr_t                      addr;  // Burst start address
	logic [31:0]                len;   // Beats in burst
	logic [2:0]                 size;  // log2 of bytes per beat
	burst_kind_t                burst;
	pixel_t                     data;
	logic [`FRAME_DATA_W/8-1:0] strb;  // Byte enables
	logic                       beat;  // Data strobe

	// Writer side
	modport writer (
		output start, addr, len, size, burst, data, strb, beat
	);

	// Memory side, never stalls so no ready
	modport memory (
		input start, addr, len, size, burst, data, strb, beat
	);

endinterface

// ==== hw/stream_input_stage.sv ====
`timescale 1ns/10ps

module stream_input_stage import frame_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  pixel_t s_tdata,
	input  logic   s_tvalid,
	input  logic   s_tlast,
	input  logic   s_tuser,
	output logic   s_tready,
	input  logic   take,       // Consumer empties the register this cycle
	output logic   beat_valid,
	output pixel_t beat_data,
	output logic   beat_last,
	output logic   beat_user
);

	logic armed; // Low only in the first cycle after reset
	logic full;  // Register holds an untaken beat
	logic xfer;

	// Empty, or emptied in the same cycle
	assign s_tready = armed && (!full || take);
	assign xfer     = s_tvalid && s_tready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
			full  <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (xfer)
				full <= 1'b1; // Refill wins over take
			else if (take)
				full <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (xfer) begin
			beat_data <= s_tdata;
			beat_last <= s_tlast; // End of line
			beat_user <= s_tuser; // Start of frame
		end
	end

	assign beat_valid = full;

endmodule

// ==== hw/pixel_delay_line.sv ====
`timescale 1ns/10ps
`include "frame_config.svh"

module pixel_delay_line import frame_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   shift_en,
	input  logic   in_valid,
	input  pixel_t in_data,
	output logic   out_valid,
	output pixel_t out_data
);

	localparam int DEPTH = `FRAME_DELAY_DEPTH;

	logic [DEPTH-1:0] valid_q;        // Bit 0 is the newest stage
	pixel_t           data_q [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= '0;
		else if (shift_en)
			valid_q <= {valid_q[DEPTH-2:0], in_valid}; // Bubbles shift too
	end

	always_ff @(posedge clk) begin
		if (shift_en) begin
			data_q[0] <= in_data;
			for (int i = 1; i < DEPTH; i++)
				data_q[i] <= data_q[i-1];
		end
	end

	// Oldest stage
	assign out_valid = valid_q[DEPTH-1];
	assign out_data  = data_q[DEPTH-1];

endmodule

// ==== hw/memory_writer.sv ====
`timescale 1ns/10ps
`include "frame_config.svh"

module memory_writer import frame_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] pixels_per_frame,
	input  logic [15:0] frame_height,     // Lines per frame
	input  pixel_t      s_axis_tdata,
	input  logic        s_axis_tvalid,
	input  logic        s_axis_tlast,     // End of line
	input  logic        s_axis_tuser,     // Start of frame
	output logic        s_axis_tready,
	mem_write_if.writer wr,
	output logic        frame_ready,
	output addr_t       base_addr_out
);

	localparam int FLIGHT_W = $clog2(`FRAME_DELAY_DEPTH + 1);
	localparam int SLOT_W   = $clog2(`FRAME_SLOTS);

	writer_state_t       state, next_state;
	logic [SLOT_W-1:0]   slot;       // Frame buffer index
	logic [15:0]         line_count;
	logic [FLIGHT_W-1:0] in_flight;  // Valid stages in the delay line
	addr_t               frame_base;

	logic   beat_valid, beat_last, beat_user;
	pixel_t beat_data;
	logic   take, pixel_in, sof, lines_done, shift_en;
	logic   dl_valid;
	pixel_t dl_data;

	stream_input_stage i_input (
		.clk        (clk),
		.rst_n      (rst_n),
		.s_tdata    (s_axis_tdata),
		.s_tvalid   (s_axis_tvalid),
		.s_tlast    (s_axis_tlast),
		.s_tuser    (s_axis_tuser),
		.s_tready   (s_axis_tready),
		.take       (take),
		.beat_valid (beat_valid),
		.beat_data  (beat_data),
		.beat_last  (beat_last),
		.beat_user  (beat_user)
	);

	pixel_delay_line i_delay (
		.clk       (clk),
		.rst_n     (rst_n),
		.shift_en  (shift_en),
		.in_valid  (pixel_in),
		.in_data   (beat_data),
		.out_valid (dl_valid),
		.out_data  (dl_data)
	);

	assign frame_base = pixels_per_frame * addr_t'(slot);
	assign sof        = (state == IDLE) && beat_valid && beat_user;
	assign lines_done = line_count == frame_height;

	// Beats without tuser in IDLE are taken and dropped to resync
	assign take     = beat_valid && ((state == IDLE) || (state == RECEIVE && !lines_done));
	assign pixel_in = take && (state == RECEIVE || beat_user);
	assign shift_en = (state != IDLE) || take; // Keeps draining after the last take

	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (sof) next_state = RECEIVE;
			RECEIVE:    if (lines_done && in_flight == '0) next_state = FRAME_DONE;
			FRAME_DONE: next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= IDLE;
			slot          <= '0;
			line_count    <= '0;
			in_flight     <= '0;
			base_addr_out <= '0;
		end else begin
			state <= next_state;
			if (sof) begin
				line_count    <= {15'd0, beat_last}; // One-pixel line is legal
				base_addr_out <= frame_base;
			end else if (state == RECEIVE && take && beat_last) begin
				line_count <= line_count + 16'd1;
			end
			case ({pixel_in, dl_valid})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
			if (state == FRAME_DONE)
				slot <= (slot == SLOT_W'(`FRAME_SLOTS - 1)) ? '0 : slot + 1'b1;
		end
	end

	assign frame_ready = state == FRAME_DONE;

	// Write bus
	assign wr.start = sof;
	assign wr.addr  = frame_base;
	assign wr.len   = (state != IDLE || sof) ? pixels_per_frame : 32'd0;
	assign wr.burst = (state != IDLE || sof) ? INCR : FIXED; // FIXED stops stray writes
	assign wr.size  = 3'd2;                                  // 4-byte words
	assign wr.strb  = '1;
	assign wr.data  = dl_data;
	assign wr.beat  = dl_valid;

endmodule

// ==== hw/frame_buffer_mem.sv ====
`timescale 1ns/10ps
`include "frame_config.svh"

module frame_buffer_mem import frame_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	mem_write_if.memory wr,
	input  addr_t       rd_addr,
	output pixel_t      rd_data
);

	localparam int         WORDS     = `FRAME_MEM_WORDS;
	localparam int         IDX_W     = $clog2(WORDS);
	localparam int         BYTES     = `FRAME_DATA_W / 8;
	localparam logic [2:0] WORD_SIZE = 3'($clog2(BYTES));

	pixel_t      mem [WORDS];
	addr_t       wr_ptr;
	logic [31:0] remaining;  // Beats left in the burst
	logic        take_beat;
	logic        in_range;

	// Only full-word beats inside the burst count
	assign take_beat = wr.beat && (wr.size == WORD_SIZE) && (remaining != 32'd0);
	assign in_range  = wr_ptr < addr_t'(WORDS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			remaining <= '0;
		end else if (wr.start) begin
			wr_ptr    <= wr.addr;
			remaining <= wr.len;
		end else if (take_beat) begin
			remaining <= remaining - 32'd1;
			if (wr.burst == INCR)
				wr_ptr <= wr_ptr + addr_t'(1);
		end
	end

	// Byte lanes, out of range beats are dropped
	always_ff @(posedge clk) begin
		if (take_beat && in_range) begin
			for (int b = 0; b < BYTES; b++)
				if (wr.strb[b])
					mem[wr_ptr[IDX_W-1:0]][8*b +: 8] <= wr.data[8*b +: 8];
		end
	end

	// Inspection port
	assign rd_data = (rd_addr < addr_t'(WORDS)) ? mem[rd_addr[IDX_W-1:0]] : '0;

endmodule

// ==== hw/frame_store_top.sv ====
`timescale 1ns/10ps

module frame_store_top import frame_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] pixels_per_frame,
	input  logic [15:0] frame_height,
	input  pixel_t      s_axis_tdata,
	input  logic        s_axis_tvalid,
	input  logic        s_axis_tlast,
	input  logic        s_axis_tuser,
	output logic        s_axis_tready,
	output logic        frame_ready,
	output addr_t       base_addr_out,
	input  addr_t       rd_addr,
	output pixel_t      rd_data
);

	mem_write_if wr_bus ();

	memory_writer i_writer (
		.clk              (clk),
		.rst_n            (rst_n),
		.pixels_per_frame (pixels_per_frame),
		.frame_height     (frame_height),
		.s_axis_tdata     (s_axis_tdata),
		.s_axis_tvalid    (s_axis_tvalid),
		.s_axis_tlast     (s_axis_tlast),
		.s_axis_tuser     (s_axis_tuser),
		.s_axis_tready    (s_axis_tready),
		.wr               (wr_bus.writer),
		.frame_ready      (frame_ready),
		.base_addr_out    (base_addr_out)
	);

	// Frame store
	frame_buffer_mem i_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (wr_bus.memory),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== verif/frame_store_asserts.sv ====
`timescale 1ns/10ps

module frame_store_asserts import frame_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	input logic          start,       // Burst header strobe
	input logic          beat,        // Data strobe
	input logic          frame_ready,
	input writer_state_t state,
	input logic          tvalid,
	input logic          tready,
	input pixel_t        tdata
);

	// One header per frame
	start_single: assert property (@(posedge clk) disable iff (!rst_n) start |=> !start)
		else $error("write bus start high on two consecutive cycles");

	ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame_ready |=> !frame_ready)
		else $error("frame_ready longer than one cycle");

	// Delay line must be empty at handoff
	no_beat_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(beat && state == FRAME_DONE))
		else $error("write beat during FRAME_DONE");

	// Source side rule, a stalled beat holds still
	tdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(tvalid && !tready) |=> (tvalid && $stable(tdata)))
		else $error("stream beat changed or dropped while stalled");

endmodule

// ==== verif/frame_store_tb.sv ====
`timescale 1ns/10ps
`include "frame_config.svh"

module frame_store_tb import frame_pkg::*; ();

	localparam int NUM_FRAMES   = 6;
	localparam int MAX_PIXELS   = 48; // 8 wide by 6 high
	localparam int RESET_CYCLES = 16;
	// Worst-case gaps per pixel plus drain and handoff per frame
	localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_FRAMES * (MAX_PIXELS * 13 + 40);

	logic        clk, rst_n;
	logic [31:0] pixels_per_frame;
	logic [15:0] frame_height;
	pixel_t      s_axis_tdata, rd_data;
	logic        s_axis_tvalid, s_axis_tlast, s_axis_tuser, s_axis_tready;
	logic        frame_ready;
	addr_t       base_addr_out, rd_addr;

	pixel_t pix_data [NUM_FRAMES*MAX_PIXELS]; // All frames back to back
	logic   pix_last [NUM_FRAMES*MAX_PIXELS];
	logic   pix_user [NUM_FRAMES*MAX_PIXELS];
	int     frame_w [NUM_FRAMES], frame_h [NUM_FRAMES], frame_first [NUM_FRAMES];
	pixel_t model_mem [`FRAME_MEM_WORDS];     // Expected memory
	bit     model_set [`FRAME_MEM_WORDS];
	int     model_top, total_pixels;

	logic [31:0] rng_state;
	int          errors, tests_run, tests_failed, cycle_count, frames_done, extra_pulses;
	bit          prev_ready, timed_out;

	frame_store_top i_dut (.*);

	bind memory_writer frame_store_asserts i_asserts (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (sof),
		.beat        (dl_valid),
		.frame_ready (frame_ready),
		.state       (state),
		.tvalid      (s_axis_tvalid),
		.tready      (s_axis_tready),
		.tdata       (s_axis_tdata)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// Random sizes and pixels, tuser on pixel 0, tlast at each line end
	task automatic build_frames();
		int n;
		n = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			frame_w[f]     = 2 + int'(next_rand() % 7);
			frame_h[f]     = 2 + int'(next_rand() % 5);
			frame_first[f] = n;
			for (int p = 0; p < frame_w[f] * frame_h[f]; p++) begin
				pix_data[n] = next_rand();
				pix_user[n] = (p == 0);
				pix_last[n] = (p % frame_w[f]) == frame_w[f] - 1;
				n++;
			end
		end
		total_pixels = n;
	endtask

	task automatic apply_config(input int f);
		pixels_per_frame = 32'(frame_w[f] * frame_h[f]);
		frame_height     = 16'(frame_h[f]);
	endtask

	// Called in FRAME_DONE, memory is quiet for this cycle
	task automatic finish_frame();
		int f, ppf, base, err_before;
		f          = frames_done;
		ppf        = frame_w[f] * frame_h[f];
		base       = ppf * (f % `FRAME_SLOTS); // Slots rotate 0, 1, 2
		err_before = errors;
		check_value("base_addr_out", base_addr_out, 32'(base));
		for (int p = 0; p < ppf; p++) begin
			model_mem[base + p] = pix_data[frame_first[f] + p];
			model_set[base + p] = 1'b1;
		end
		if (base + ppf > model_top)
			model_top = base + ppf;
		// Whole written region, older frames included
		for (int a = 0; a < model_top; a++) begin
			if (model_set[a]) begin
				rd_addr = addr_t'(a);
				#0.05;
				check_value($sformatf("rd_data[%0d]", a), rd_data, model_mem[a]);
			end
		end
		if (f < NUM_FRAMES - 1) begin
			check_value("s_axis_tvalid", 32'(s_axis_tvalid), 32'd1); // Next frame waiting
			check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
			apply_config(f + 1);
		end
		report_test($sformatf("frame %0d (%0dx%0d at %0d)", f, frame_w[f], frame_h[f], base),
			err_before);
		frames_done++;
	endtask

	task automatic observe_cycle();
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT && !timed_out) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout after %0d cycles, frame_ready never came for frame %0d",
				cycle_count, frames_done);
		end
		if (frame_ready) begin
			if (prev_ready) begin
				errors++;
				$display("frame_ready stayed high for more than one cycle at %0t", $time);
			end else if (frames_done >= NUM_FRAMES)
				extra_pulses++;
			else
				finish_frame();
		end
		prev_ready = frame_ready;
	endtask

	initial begin
		int idx, wait_cnt, err_before;
		bit ready_q;
		rng_state     = 32'd14;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		cycle_count   = 0;
		frames_done   = 0;
		extra_pulses  = 0;
		model_top     = 0;
		prev_ready    = 1'b0;
		timed_out     = 1'b0;
		rst_n         = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		s_axis_tuser  = 1'b0;
		rd_addr       = '0;
		build_frames();
		apply_config(0);

		err_before = errors;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
			check_value("frame_ready", 32'(frame_ready), 32'd0);
			check_value("base_addr_out", base_addr_out, 32'd0);
		end
		rst_n = 1'b1;
		report_test("reset state", err_before);

		idx      = 0;
		wait_cnt = 0;
		ready_q  = 1'b0;
		while (frames_done < NUM_FRAMES && !timed_out) begin
			@(negedge clk);
			observe_cycle();
			if (s_axis_tvalid && ready_q) begin // Taken at the last rising edge
				s_axis_tvalid = 1'b0;
				idx++;
				// No gap on a frame's first two beats, so they back up behind the writer
				if (idx < total_pixels && !pix_user[idx] && !pix_user[idx-1])
					wait_cnt = int'(next_rand() % 3);
			end
			if (!s_axis_tvalid && idx < total_pixels) begin
				if (wait_cnt > 0) begin
					wait_cnt--;
				end else begin
					s_axis_tdata  = pix_data[idx];
					s_axis_tlast  = pix_last[idx];
					s_axis_tuser  = pix_user[idx];
					s_axis_tvalid = 1'b1;
				end
			end
			ready_q = s_axis_tready;
		end

		// Quiet tail, any pulse here is one too many
		repeat (30) begin
			@(negedge clk);
			observe_cycle();
		end
		err_before = errors;
		check_value("frames completed", 32'(frames_done), 32'(NUM_FRAMES));
		check_value("extra frame_ready pulses", 32'(extra_pulses), 32'd0);
		report_test("frame_ready count", err_before);

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/frame_pkg.sv
hw/mem_write_if.sv
hw/stream_input_stage.sv
hw/pixel_delay_line.sv
hw/memory_writer.sv
hw/frame_buffer_mem.sv
hw/frame_store_top.sv
verif/frame_store_asserts.sv
verif/frame_store_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= frame_store_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= ERRORS FOUND
PASS_MSG   ?= NO ERRORS

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) hw/frame_config.svh

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
